//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
+incdir+verilog
verilog/id_pkg.sv
verilog/id_regfile.sv
verilog/special_decoder.sv
verilog/imm_decoder.sv
verilog/operand_select.sv
verilog/id_stage.sv
sim/id_properties.sv
sim/tb_id_stage.sv

//--- sim/id_properties.sv
`timescale 1ns/1ps

module id_properties (
    input logic clk,
    input logic rst_i,
    input logic inst_valid_i,
    input logic ex_valid_i,
    input logic ex_wreg_i,
    input logic ex_invalid_i
);
    int fail_count = 0;

    wreg_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        ex_wreg_i |-> ex_valid_i)
    else begin
        $error("ex_wreg_o high while ex_valid_o is low");
        fail_count++;
    end

    invalid_blocks_write: assert property (@(posedge clk) disable iff (rst_i)
        ex_invalid_i |-> !ex_wreg_i)
    else begin
        $error("ex_wreg_o high for an invalid instruction");
        fail_count++;
    end

    // one stage of latency
    valid_follows_input: assert property (@(posedge clk) disable iff (rst_i)
        $past(!rst_i) |-> ex_valid_i == $past(inst_valid_i))
    else begin
        $error("ex_valid_o does not follow inst_valid_i by one cycle");
        fail_count++;
    end

    controls_clear_after_reset: assert property (@(posedge clk)
        $past(rst_i) && !rst_i |-> !ex_valid_i && !ex_wreg_i && !ex_invalid_i)
    else begin
        $error("control outputs not low right after reset");
        fail_count++;
    end

endmodule

bind id_stage id_properties u_id_properties (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .ex_valid_i   (ex_valid_o),
    .ex_wreg_i    (ex_wreg_o),
    .ex_invalid_i (ex_invalid_o)
);

//--- sim/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTS    = 3000;
    // twice the expected run length
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_INSTS + 4) * CLK_PERIOD * 2;

    // and or xor nor sllv srlv srav add addu sub subu slt sltu movn movz
    localparam logic [5:0] REG_FUNCS [15] = '{
        6'h24, 6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07, 6'h20,
        6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b, 6'h0b, 6'h0a
    };
    localparam logic [5:0] SHIFT_FUNCS [3] = '{6'h00, 6'h02, 6'h03};
    // ori andi xori lui addi addiu slti sltiu
    localparam logic [5:0] IMM_OPS [8] = '{
        6'h0d, 6'h0c, 6'h0e, 6'h0f, 6'h08, 6'h09, 6'h0a, 6'h0b
    };

    logic                clk;
    logic                rst_i;
    logic                inst_valid_i;
    logic [`ID_XLEN-1:0] inst_i;
    logic                wb_we_i;
    logic [`ID_RAW-1:0]  wb_addr_i;
    logic [`ID_XLEN-1:0] wb_data_i;
    logic                ex_valid_o;
    logic                ex_invalid_o;
    alu_sel_e            ex_alusel_o;
    alu_op_e             ex_aluop_o;
    logic [`ID_XLEN-1:0] ex_reg1_o;
    logic [`ID_XLEN-1:0] ex_reg2_o;
    logic [`ID_RAW-1:0]  ex_waddr_o;
    logic                ex_wreg_o;

    logic [`ID_XLEN-1:0] model_regs [0:`ID_NREGS-1];
    logic [15:0]         lfsr;

    // expected outputs for the instruction driven last
    logic [`ID_XLEN-1:0] exp_inst;
    logic                exp_valid;
    logic                exp_invalid;
    logic                exp_wreg;
    alu_sel_e            exp_sel;
    alu_op_e             exp_op;
    logic [`ID_XLEN-1:0] exp_reg1;
    logic [`ID_XLEN-1:0] exp_reg2;
    logic [`ID_RAW-1:0]  exp_waddr;

    id_stage u_id_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_we_i      (wb_we_i),
        .wb_addr_i    (wb_addr_i),
        .wb_data_i    (wb_data_i),
        .ex_valid_o   (ex_valid_o),
        .ex_invalid_o (ex_invalid_o),
        .ex_alusel_o  (ex_alusel_o),
        .ex_aluop_o   (ex_aluop_o),
        .ex_reg1_o    (ex_reg1_o),
        .ex_reg2_o    (ex_reg2_o),
        .ex_waddr_o   (ex_waddr_o),
        .ex_wreg_o    (ex_wreg_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_advance(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // register read as seen in the decode cycle with write-back forwarded
    function automatic logic [`ID_XLEN-1:0] model_read(input logic [`ID_RAW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_we_i && wb_addr_i == addr) begin
            return wb_data_i;
        end
        return model_regs[addr];
    endfunction

    function automatic alu_op_e special_op(input logic [5:0] fn);
        case (fn)
            6'h24:        return ALU_AND;
            6'h25:        return ALU_OR;
            6'h26:        return ALU_XOR;
            6'h27:        return ALU_NOR;
            6'h00, 6'h04: return ALU_SLL;
            6'h02, 6'h06: return ALU_SRL;
            6'h03, 6'h07: return ALU_SRA;
            6'h20:        return ALU_ADD;
            6'h21:        return ALU_ADDU;
            6'h22:        return ALU_SUB;
            6'h23:        return ALU_SUBU;
            6'h2a:        return ALU_SLT;
            6'h2b:        return ALU_SLTU;
            6'h0b:        return ALU_MOVN;
            6'h0a:        return ALU_MOVZ;
            default:      return ALU_NOP;
        endcase
    endfunction

    function automatic alu_op_e immediate_op(input logic [5:0] op);
        case (op)
            6'h08:        return ALU_ADD;
            6'h09:        return ALU_ADDU;
            6'h0a:        return ALU_SLT;
            6'h0b:        return ALU_SLTU;
            6'h0c:        return ALU_AND;
            6'h0d, 6'h0f: return ALU_OR;
            6'h0e:        return ALU_XOR;
            default:      return ALU_NOP;
        endcase
    endfunction

    function automatic alu_sel_e class_of(input alu_op_e aop);
        case (aop)
            ALU_NOP:                           return SEL_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
            ALU_MOVN, ALU_MOVZ:                return SEL_MOVE;
            default:                           return SEL_ARITH;
        endcase
    endfunction

    task automatic predict(input logic [`ID_XLEN-1:0] inst, input logic valid);
        logic [5:0]         op;
        logic [5:0]         fn;
        logic [`ID_RAW-1:0] rs;
        logic [`ID_RAW-1:0] rt;
        logic [`ID_RAW-1:0] rd;
        logic [4:0]         sh;
        logic [15:0]        imm16;
        logic               known;
        logic               wr;
        op        = inst[`ID_OP_LSB +: 6];
        fn        = inst[5:0];
        rs        = inst[`ID_RS_LSB +: `ID_RAW];
        rt        = inst[`ID_RT_LSB +: `ID_RAW];
        rd        = inst[`ID_RD_LSB +: `ID_RAW];
        sh        = inst[`ID_SHAMT_LSB +: 5];
        imm16     = inst[15:0];
        known     = 1'b0;
        wr        = 1'b0;
        exp_op    = ALU_NOP;
        exp_reg1  = '0;
        exp_reg2  = '0;
        exp_waddr = '0;
        if (op == 6'h00) begin
            if (sh == 5'd0 && fn inside {6'h00, 6'h0f}) begin
                // nop and sync
                known = 1'b1;
            end else if (sh == 5'd0 &&
                         fn inside {[6'h20:6'h27], 6'h2a, 6'h2b, 6'h04, 6'h06, 6'h07,
                                    6'h0a, 6'h0b}) begin
                known     = 1'b1;
                wr        = 1'b1;
                exp_op    = special_op(fn);
                exp_waddr = rd;
                exp_reg1  = model_read(rs);
                exp_reg2  = model_read(rt);
                if (class_of(exp_op) == SEL_SHIFT) begin
                    // variable shifts move rt by rs
                    exp_reg1 = model_read(rt);
                    exp_reg2 = model_read(rs);
                end
            end else if (sh != 5'd0 && inst == 32'h0000_0040) begin
                // ssnop still carries its shamt into operand 2
                known    = 1'b1;
                exp_reg2 = 32'(sh);
            end else if (sh != 5'd0 && fn inside {6'h00, 6'h02, 6'h03}) begin
                known     = 1'b1;
                wr        = 1'b1;
                exp_op    = special_op(fn);
                exp_waddr = rd;
                exp_reg1  = model_read(rt);
                exp_reg2  = 32'(sh);
            end
        end else if (op inside {[6'h08:6'h0f]}) begin
            known     = 1'b1;
            wr        = 1'b1;
            exp_op    = immediate_op(op);
            exp_waddr = rt;
            exp_reg1  = model_read(rs);
            if (op == 6'h0f) begin
                exp_reg2 = {imm16, 16'h0000};
            end else if (op inside {[6'h0c:6'h0e]}) begin
                exp_reg2 = {16'h0000, imm16};
            end else begin
                exp_reg2 = {{16{imm16[15]}}, imm16};
            end
        end
        if (exp_op == ALU_MOVN) begin
            wr = (exp_reg2 != '0);
        end else if (exp_op == ALU_MOVZ) begin
            wr = (exp_reg2 == '0);
        end
        exp_sel     = class_of(exp_op);
        exp_valid   = valid;
        exp_wreg    = valid && wr;
        exp_invalid = valid && !known;
    endtask

    task automatic drive_cycle();
        logic [4:0]          pick;
        logic [`ID_RAW-1:0]  rs;
        logic [`ID_RAW-1:0]  rt;
        logic [`ID_RAW-1:0]  rd;
        logic [4:0]          sh;
        logic [15:0]         imm;
        logic [1:0]          wb_pick;
        logic [`ID_XLEN-1:0] inst;
        pick = 5'(rand_bits(5));
        rs   = 5'(rand_bits(5));
        rt   = 5'(rand_bits(5));
        rd   = 5'(rand_bits(5));
        sh   = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        if (pick < 5'd15) begin
            inst = {6'h00, rs, rt, rd, 5'd0, REG_FUNCS[4'(pick)]};
        end else if (pick < 5'd18) begin
            inst = {6'h00, rs, rt, rd, sh, SHIFT_FUNCS[2'(pick - 5'd15)]};
        end else if (pick == 5'd18) begin
            inst = '0;
        end else if (pick == 5'd19) begin
            inst = 32'h0000_0040;
        end else if (pick == 5'd20) begin
            inst = 32'h0000_000f;
        end else if (pick == 5'd24) begin
            // lui with rs zero
            inst = {IMM_OPS[3], 5'd0, rt, imm};
        end else if (pick < 5'd29) begin
            inst = {IMM_OPS[3'(pick - 5'd21)], rs, rt, imm};
        end else if (pick == 5'd29) begin
            inst = rand_bits(32);
        end else if (pick == 5'd30) begin
            inst = {6'h00, rs, rt, rd, sh, 6'(rand_bits(6))};
        end else begin
            inst = {6'h3f, rs, rt, rd, sh, 6'(rand_bits(6))};
        end
        inst_valid_i = (rand_bits(2) != 32'd0);
        inst_i       = inst;
        exp_inst     = inst;
        wb_we_i      = 1'(rand_bits(1));
        wb_pick      = 2'(rand_bits(2));
        // aim write-back at the source fields to hit forwarding
        if (wb_pick == 2'd0) begin
            wb_addr_i = inst[`ID_RS_LSB +: `ID_RAW];
        end else if (wb_pick == 2'd1) begin
            wb_addr_i = inst[`ID_RT_LSB +: `ID_RAW];
        end else begin
            wb_addr_i = 5'(rand_bits(5));
        end
        if (rand_bits(2) == 32'd0) begin
            wb_data_i = '0;
        end else begin
            wb_data_i = rand_bits(32);
        end
        predict(inst, inst_valid_i);
        if (wb_we_i && wb_addr_i != '0) begin
            model_regs[wb_addr_i] = wb_data_i;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_assertions(input string tag);
        if (u_id_stage.u_id_properties.fail_count != 0) begin
            $display("a bound assertion failed by %s", tag);
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic compare_outputs(input int n);
        string tag;
        tag = $sformatf("cycle %0d inst %08h", n, exp_inst);
        check_value({tag, " ex_valid_o"}, 32'(exp_valid), 32'(ex_valid_o));
        check_value({tag, " ex_wreg_o"}, 32'(exp_wreg), 32'(ex_wreg_o));
        check_value({tag, " ex_invalid_o"}, 32'(exp_invalid), 32'(ex_invalid_o));
        if (exp_valid) begin
            check_value({tag, " ex_alusel_o"}, 32'(exp_sel), 32'(ex_alusel_o));
            check_value({tag, " ex_aluop_o"}, 32'(exp_op), 32'(ex_aluop_o));
            check_value({tag, " ex_reg1_o"}, exp_reg1, ex_reg1_o);
            check_value({tag, " ex_reg2_o"}, exp_reg2, ex_reg2_o);
            check_value({tag, " ex_waddr_o"}, 32'(exp_waddr), 32'(ex_waddr_o));
        end
        check_assertions(tag);
    endtask

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_we_i      = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        exp_inst     = '0;
        lfsr         = 16'd17012;
        for (int i = 0; i < `ID_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("reset ex_valid_o", 32'd0, 32'(ex_valid_o));
        check_value("reset ex_wreg_o", 32'd0, 32'(ex_wreg_o));
        check_value("reset ex_invalid_o", 32'd0, 32'(ex_invalid_o));
        rst_i = 1'b0;
        for (int n = 0; n < NUM_INSTS; n++) begin
            drive_cycle();
            @(negedge clk);
            compare_outputs(n);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog/id_pkg.sv
package id_pkg;

    // primary opcodes kept by this stage
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function codes
    // nop and ssnop share the sll code
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_SYNC = 6'b001111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } func_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alu_sel_e;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'b00000000,
        ALU_SRL  = 8'b00000010,
        ALU_SRA  = 8'b00000011,
        ALU_MOVZ = 8'b00001010,
        ALU_MOVN = 8'b00001011,
        ALU_ADD  = 8'b00100000,
        ALU_ADDU = 8'b00100001,
        ALU_SUB  = 8'b00100010,
        ALU_SUBU = 8'b00100011,
        ALU_AND  = 8'b00100100,
        ALU_OR   = 8'b00100101,
        ALU_XOR  = 8'b00100110,
        ALU_NOR  = 8'b00100111,
        ALU_SLT  = 8'b00101010,
        ALU_SLTU = 8'b00101011,
        ALU_SLL  = 8'b01111100
    } alu_op_e;

endpackage

//--- verilog/id_regfile.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_regfile (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                we_i,
    input  logic [`ID_RAW-1:0]  waddr_i,
    input  logic [`ID_XLEN-1:0] wdata_i,
    input  logic                re1_i,
    input  logic [`ID_RAW-1:0]  raddr1_i,
    output logic [`ID_XLEN-1:0] rdata1_o,
    input  logic                re2_i,
    input  logic [`ID_RAW-1:0]  raddr2_i,
    output logic [`ID_XLEN-1:0] rdata2_o
);
    logic [`ID_XLEN-1:0] regs [0:`ID_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero and a pending write-back is forwarded
    function automatic logic [`ID_XLEN-1:0] read_port(input logic re,
                                                       input logic [`ID_RAW-1:0] raddr);
        if (!re || raddr == '0) begin
            return '0;
        end else if (we_i && waddr_i == raddr) begin
            return wdata_i;
        end
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i);
        rdata2_o = read_port(re2_i, raddr2_i);
    end

endmodule

//--- verilog/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and register file
`define ID_XLEN      32
`define ID_NREGS     32
`define ID_RAW       5

// instruction field positions
`define ID_OP_LSB    26
`define ID_RS_LSB    21
`define ID_RT_LSB    16
`define ID_RD_LSB    11
`define ID_SHAMT_LSB 6

`endif

//--- verilog/id_stage.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage import id_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                inst_valid_i,
    input  logic [`ID_XLEN-1:0] inst_i,
    input  logic                wb_we_i,
    input  logic [`ID_RAW-1:0]  wb_addr_i,
    input  logic [`ID_XLEN-1:0] wb_data_i,
    output logic                ex_valid_o,
    output logic                ex_invalid_o,
    output alu_sel_e            ex_alusel_o,
    output alu_op_e             ex_aluop_o,
    output logic [`ID_XLEN-1:0] ex_reg1_o,
    output logic [`ID_XLEN-1:0] ex_reg2_o,
    output logic [`ID_RAW-1:0]  ex_waddr_o,
    output logic                ex_wreg_o
);
    // SPECIAL decoder results
    logic                sp_hit;
    alu_sel_e            sp_alusel;
    alu_op_e             sp_aluop;
    logic [`ID_RAW-1:0]  sp_waddr;
    logic                sp_wreg;
    logic                sp_re1;
    logic [`ID_RAW-1:0]  sp_raddr1;
    logic                sp_re2;
    logic [`ID_RAW-1:0]  sp_raddr2;
    logic [`ID_XLEN-1:0] sp_shamt_imm;

    // immediate decoder results
    logic                im_hit;
    alu_sel_e            im_alusel;
    alu_op_e             im_aluop;
    logic [`ID_RAW-1:0]  im_waddr;
    logic                im_wreg;
    logic                im_re1;
    logic [`ID_RAW-1:0]  im_raddr1;
    logic [`ID_XLEN-1:0] im_imm;

    logic                rf_re1;
    logic [`ID_RAW-1:0]  rf_raddr1;
    logic                rf_re2;
    logic [`ID_RAW-1:0]  rf_raddr2;
    logic [`ID_XLEN-1:0] rf_rdata1;
    logic [`ID_XLEN-1:0] rf_rdata2;

    special_decoder u_special_decoder (
        .inst_i      (inst_i),
        .hit_o       (sp_hit),
        .alusel_o    (sp_alusel),
        .aluop_o     (sp_aluop),
        .waddr_o     (sp_waddr),
        .wreg_o      (sp_wreg),
        .re1_o       (sp_re1),
        .raddr1_o    (sp_raddr1),
        .re2_o       (sp_re2),
        .raddr2_o    (sp_raddr2),
        .shamt_imm_o (sp_shamt_imm)
    );

    imm_decoder u_imm_decoder (
        .inst_i   (inst_i),
        .hit_o    (im_hit),
        .alusel_o (im_alusel),
        .aluop_o  (im_aluop),
        .waddr_o  (im_waddr),
        .wreg_o   (im_wreg),
        .re1_o    (im_re1),
        .raddr1_o (im_raddr1),
        .imm_o    (im_imm)
    );

    operand_select u_operand_select (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .sp_hit_i       (sp_hit),
        .sp_alusel_i    (sp_alusel),
        .sp_aluop_i     (sp_aluop),
        .sp_waddr_i     (sp_waddr),
        .sp_wreg_i      (sp_wreg),
        .sp_re1_i       (sp_re1),
        .sp_raddr1_i    (sp_raddr1),
        .sp_re2_i       (sp_re2),
        .sp_raddr2_i    (sp_raddr2),
        .sp_shamt_imm_i (sp_shamt_imm),
        .im_hit_i       (im_hit),
        .im_alusel_i    (im_alusel),
        .im_aluop_i     (im_aluop),
        .im_waddr_i     (im_waddr),
        .im_wreg_i      (im_wreg),
        .im_re1_i       (im_re1),
        .im_raddr1_i    (im_raddr1),
        .im_imm_i       (im_imm),
        .rf_re1_o       (rf_re1),
        .rf_raddr1_o    (rf_raddr1),
        .rf_re2_o       (rf_re2),
        .rf_raddr2_o    (rf_raddr2),
        .rf_rdata1_i    (rf_rdata1),
        .rf_rdata2_i    (rf_rdata2),
        .ex_valid_o     (ex_valid_o),
        .ex_invalid_o   (ex_invalid_o),
        .ex_alusel_o    (ex_alusel_o),
        .ex_aluop_o     (ex_aluop_o),
        .ex_reg1_o      (ex_reg1_o),
        .ex_reg2_o      (ex_reg2_o),
        .ex_waddr_o     (ex_waddr_o),
        .ex_wreg_o      (ex_wreg_o)
    );

    id_regfile u_id_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .re1_i    (rf_re1),
        .raddr1_i (rf_raddr1),
        .rdata1_o (rf_rdata1),
        .re2_i    (rf_re2),
        .raddr2_i (rf_raddr2),
        .rdata2_o (rf_rdata2)
    );

endmodule

//--- verilog/imm_decoder.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module imm_decoder import id_pkg::*; (
    input  logic [`ID_XLEN-1:0] inst_i,
    output logic                hit_o,
    output alu_sel_e            alusel_o,
    output alu_op_e             aluop_o,
    output logic [`ID_RAW-1:0]  waddr_o,
    output logic                wreg_o,
    output logic                re1_o,
    output logic [`ID_RAW-1:0]  raddr1_o,
    output logic [`ID_XLEN-1:0] imm_o
);
    opcode_e            op;
    logic [`ID_RAW-1:0] rs;
    logic [`ID_RAW-1:0] rt;
    logic [15:0]        imm16;

    assign op    = opcode_e'(inst_i[`ID_OP_LSB +: 6]);
    assign rs    = inst_i[`ID_RS_LSB +: `ID_RAW];
    assign rt    = inst_i[`ID_RT_LSB +: `ID_RAW];
    assign imm16 = inst_i[15:0];

    always_comb begin
        hit_o    = 1'b1;
        alusel_o = SEL_LOGIC;
        aluop_o  = ALU_NOP;
        case (op)
            OP_ANDI:  aluop_o = ALU_AND;
            OP_XORI:  aluop_o = ALU_XOR;
            // lui is an or with r0
            OP_ORI, OP_LUI: aluop_o = ALU_OR;
            OP_ADDI:  aluop_o = ALU_ADD;
            OP_ADDIU: aluop_o = ALU_ADDU;
            OP_SLTI:  aluop_o = ALU_SLT;
            OP_SLTIU: aluop_o = ALU_SLTU;
            default: begin
                hit_o    = 1'b0;
                alusel_o = SEL_NOP;
            end
        endcase
        if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
            alusel_o = SEL_ARITH;
        end
    end

    // arithmetic forms sign-extend, logic forms zero-extend
    always_comb begin
        if (op == OP_LUI) begin
            imm_o = {imm16, {(`ID_XLEN-16){1'b0}}};
        end else if (alusel_o == SEL_ARITH) begin
            imm_o = {{(`ID_XLEN-16){imm16[15]}}, imm16};
        end else begin
            imm_o = {{(`ID_XLEN-16){1'b0}}, imm16};
        end
    end

    assign wreg_o   = hit_o;
    assign waddr_o  = hit_o ? rt : '0;
    assign re1_o    = hit_o;
    assign raddr1_o = rs;

endmodule

//--- verilog/operand_select.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_select import id_pkg::*; (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                inst_valid_i,
    input  logic                sp_hit_i,
    input  alu_sel_e            sp_alusel_i,
    input  alu_op_e             sp_aluop_i,
    input  logic [`ID_RAW-1:0]  sp_waddr_i,
    input  logic                sp_wreg_i,
    input  logic                sp_re1_i,
    input  logic [`ID_RAW-1:0]  sp_raddr1_i,
    input  logic                sp_re2_i,
    input  logic [`ID_RAW-1:0]  sp_raddr2_i,
    input  logic [`ID_XLEN-1:0] sp_shamt_imm_i,
    input  logic                im_hit_i,
    input  alu_sel_e            im_alusel_i,
    input  alu_op_e             im_aluop_i,
    input  logic [`ID_RAW-1:0]  im_waddr_i,
    input  logic                im_wreg_i,
    input  logic                im_re1_i,
    input  logic [`ID_RAW-1:0]  im_raddr1_i,
    input  logic [`ID_XLEN-1:0] im_imm_i,
    output logic                rf_re1_o,
    output logic [`ID_RAW-1:0]  rf_raddr1_o,
    output logic                rf_re2_o,
    output logic [`ID_RAW-1:0]  rf_raddr2_o,
    input  logic [`ID_XLEN-1:0] rf_rdata1_i,
    input  logic [`ID_XLEN-1:0] rf_rdata2_i,
    output logic                ex_valid_o,
    output logic                ex_invalid_o,
    output alu_sel_e            ex_alusel_o,
    output alu_op_e             ex_aluop_o,
    output logic [`ID_XLEN-1:0] ex_reg1_o,
    output logic [`ID_XLEN-1:0] ex_reg2_o,
    output logic [`ID_RAW-1:0]  ex_waddr_o,
    output logic                ex_wreg_o
);
    alu_sel_e            alusel;
    alu_op_e             aluop;
    logic [`ID_RAW-1:0]  waddr;
    logic                wreg;
    logic                wreg_res;
    logic [`ID_XLEN-1:0] imm;
    logic [`ID_XLEN-1:0] reg1;
    logic [`ID_XLEN-1:0] reg2;
    logic                invalid;

    // the two classes never overlap
    always_comb begin
        alusel      = SEL_NOP;
        aluop       = ALU_NOP;
        waddr       = '0;
        wreg        = 1'b0;
        rf_re1_o    = 1'b0;
        rf_raddr1_o = '0;
        rf_re2_o    = 1'b0;
        rf_raddr2_o = '0;
        imm         = '0;
        if (sp_hit_i) begin
            alusel      = sp_alusel_i;
            aluop       = sp_aluop_i;
            waddr       = sp_waddr_i;
            wreg        = sp_wreg_i;
            rf_re1_o    = sp_re1_i;
            rf_raddr1_o = sp_raddr1_i;
            rf_re2_o    = sp_re2_i;
            rf_raddr2_o = sp_raddr2_i;
            imm         = sp_shamt_imm_i;
        end else if (im_hit_i) begin
            alusel      = im_alusel_i;
            aluop       = im_aluop_i;
            waddr       = im_waddr_i;
            wreg        = im_wreg_i;
            rf_re1_o    = im_re1_i;
            rf_raddr1_o = im_raddr1_i;
            imm         = im_imm_i;
        end
    end

    assign reg1    = rf_re1_o ? rf_rdata1_i : '0;
    assign reg2    = rf_re2_o ? rf_rdata2_i : imm;
    assign invalid = !sp_hit_i && !im_hit_i;

    // conditional moves look at forwarded rt data
    always_comb begin
        wreg_res = wreg;
        if (aluop == ALU_MOVN) begin
            wreg_res = (reg2 != '0);
        end else if (aluop == ALU_MOVZ) begin
            wreg_res = (reg2 == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o   <= 1'b0;
            ex_wreg_o    <= 1'b0;
            ex_invalid_o <= 1'b0;
        end else begin
            ex_valid_o   <= inst_valid_i;
            ex_wreg_o    <= inst_valid_i && wreg_res;
            ex_invalid_o <= inst_valid_i && invalid;
        end
    end

    always_ff @(posedge clk) begin
        ex_alusel_o <= alusel;
        ex_aluop_o  <= aluop;
        ex_reg1_o   <= reg1;
        ex_reg2_o   <= reg2;
        ex_waddr_o  <= waddr;
    end

endmodule

//--- verilog/special_decoder.sv
`timescale 1ns/1ps
`include "id_settings.svh"

module special_decoder import id_pkg::*; (
    input  logic [`ID_XLEN-1:0] inst_i,
    output logic                hit_o,
    output alu_sel_e            alusel_o,
    output alu_op_e             aluop_o,
    output logic [`ID_RAW-1:0]  waddr_o,
    output logic                wreg_o,
    output logic                re1_o,
    output logic [`ID_RAW-1:0]  raddr1_o,
    output logic                re2_o,
    output logic [`ID_RAW-1:0]  raddr2_o,
    output logic [`ID_XLEN-1:0] shamt_imm_o
);
    localparam logic [`ID_XLEN-1:0] SSNOP_INST = 32'h0000_0040;

    opcode_e            op;
    func_e              func;
    logic [`ID_RAW-1:0] rs;
    logic [`ID_RAW-1:0] rt;
    logic [`ID_RAW-1:0] rd;
    logic [4:0]         shamt;
    logic               is_shift;
    logic               imm_shift;

    assign op    = opcode_e'(inst_i[`ID_OP_LSB +: 6]);
    assign func  = func_e'(inst_i[5:0]);
    assign rs    = inst_i[`ID_RS_LSB +: `ID_RAW];
    assign rt    = inst_i[`ID_RT_LSB +: `ID_RAW];
    assign rd    = inst_i[`ID_RD_LSB +: `ID_RAW];
    assign shamt = inst_i[`ID_SHAMT_LSB +: 5];

    function automatic alu_op_e func_to_aluop(input func_e f);
        case (f)
            FN_AND:          return ALU_AND;
            FN_OR:           return ALU_OR;
            FN_XOR:          return ALU_XOR;
            FN_NOR:          return ALU_NOR;
            FN_SLLV, FN_SLL: return ALU_SLL;
            FN_SRLV, FN_SRL: return ALU_SRL;
            FN_SRAV, FN_SRA: return ALU_SRA;
            FN_ADD:          return ALU_ADD;
            FN_ADDU:         return ALU_ADDU;
            FN_SUB:          return ALU_SUB;
            FN_SUBU:         return ALU_SUBU;
            FN_SLT:          return ALU_SLT;
            FN_SLTU:         return ALU_SLTU;
            FN_MOVN:         return ALU_MOVN;
            FN_MOVZ:         return ALU_MOVZ;
            default:         return ALU_NOP;
        endcase
    endfunction

    // shamt selects register forms or immediate shifts
    always_comb begin
        hit_o    = 1'b0;
        alusel_o = SEL_NOP;
        if (op == OP_SPECIAL) begin
            hit_o = 1'b1;
            if (shamt == '0) begin
                case (func)
                    FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = SEL_LOGIC;
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: alusel_o = SEL_ARITH;
                    FN_SLLV, FN_SRLV, FN_SRAV: alusel_o = SEL_SHIFT;
                    FN_MOVN, FN_MOVZ: alusel_o = SEL_MOVE;
                    // nop and sync
                    FN_SLL, FN_SYNC: alusel_o = SEL_NOP;
                    default: hit_o = 1'b0;
                endcase
            end else begin
                case (func)
                    FN_SLL: begin
                        if (inst_i != SSNOP_INST) begin
                            alusel_o = SEL_SHIFT;
                        end
                    end
                    FN_SRL, FN_SRA: alusel_o = SEL_SHIFT;
                    default: hit_o = 1'b0;
                endcase
            end
        end
    end

    always_comb begin
        aluop_o = ALU_NOP;
        if (alusel_o != SEL_NOP) begin
            aluop_o = func_to_aluop(func);
        end
    end

    // shifts take rt as operand 1
    assign is_shift    = (alusel_o == SEL_SHIFT);
    assign imm_shift   = is_shift && (shamt != '0);
    assign wreg_o      = (alusel_o != SEL_NOP);
    assign waddr_o     = wreg_o ? rd : '0;
    assign re1_o       = wreg_o;
    assign raddr1_o    = is_shift ? rt : rs;
    assign re2_o       = wreg_o && !imm_shift;
    assign raddr2_o    = is_shift ? rs : rt;
    assign shamt_imm_o = {{(`ID_XLEN-5){1'b0}}, shamt};

endmodule
